// File: Bender.yml
package:
  name: pck_proc_int_mem_fsm

sources:
  - src/pck_buf_pkg.sv
  - src/pck_write_ctrl.sv
  - src/pck_data_ram.sv
  - src/pck_len_fifo.sv
  - src/pck_read_ctrl.sv
  - src/pck_proc_int_mem_fsm.sv
  - target: test
    files:
      - bench/pck_proc_tb.sv

// File: bench/pck_proc_tb.sv
module pck_proc_tb
  import pck_buf_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 2000;
  localparam int NROWS   = 22;
  // Columns of the stimulus table
  localparam int C_LEN   = 0;
  localparam int C_NW    = 1;
  localparam int C_EOP   = 2;
  localparam int C_SOP2  = 3;
  localparam int C_STALL = 4;
  localparam int C_KEEP  = 5;
  localparam int C_DROPS = 6;
  localparam int C_OVF   = 7;
  // Committed words while stalled, less the header held in the output register
  localparam int STORED  = 7 * 8 + 4 - 1;

  logic  pck_proc_int_mem_fsm_clk;
  logic  pck_proc_int_mem_fsm_rstn;
  logic  in_valid_i;
  data_t in_data_i;
  logic  in_sop_i;
  logic  in_eop_i;
  logic  in_ready_o;
  logic  out_valid_o;
  data_t out_data_o;
  logic  out_sop_o;
  logic  out_eop_o;
  logic  out_ready_i;
  logic  packet_drop_o;
  logic  overflow_o;
  logic  full_o;
  logic  empty_o;
  lvl_t  wr_lvl_o;

  int          rows [NROWS][8];
  data_t       exp_q [$];
  logic [1:0]  exp_flag_q [$];
  logic [16:0] lfsr = 17'd95648;
  int          ready_mode;
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          drop_cnt;
  int          ovf_cnt;
  lvl_t        peak;
  logic        full_seen;

  pck_proc_int_mem_fsm pck_proc_int_mem_fsm_inst (.*);

  initial
  begin
    pck_proc_int_mem_fsm_clk = 1'b0;
    forever #50 pck_proc_int_mem_fsm_clk = ~pck_proc_int_mem_fsm_clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // x^17 + x^14 + 1
  function automatic data_t rand_bits(input int n);
    data_t v;
    int    k;
    v = '0;
    for (k = 0; k < n; k++)
    begin
      lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
      v    = {v[DATA_W-2:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_lvl(input string name, input lvl_t got, input lvl_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      err_cnt++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic send_word(input data_t d, input logic sop, input logic eop);
    int t;
    in_valid_i <= 1'b1;
    in_data_i  <= d;
    in_sop_i   <= sop;
    in_eop_i   <= eop;
    t = 0;
    @(negedge pck_proc_int_mem_fsm_clk);
    while (!in_ready_o && t < TIMEOUT)
    begin
      @(negedge pck_proc_int_mem_fsm_clk);
      t++;
    end
    if (!in_ready_o)
    begin
      err_cnt++;
      $display("Timeout: input never became ready");
    end
    @(posedge pck_proc_int_mem_fsm_clk);
  endtask

  task automatic send_packet(input int len, input int nw, input int eop_at, input int keep);
    data_t words [$];
    data_t w;
    int    k;
    for (k = 1; k <= nw; k++)
    begin
      w = rand_bits(DATA_W);
      if (k == 1)
      begin
        w[LEN_W-1:0] = len_t'(len);
      end
      words.push_back(w);
      if (keep != 0)
      begin
        exp_q.push_back(w);
        exp_flag_q.push_back({k == 1, k == nw});
      end
    end
    @(posedge pck_proc_int_mem_fsm_clk);
    for (k = 1; k <= nw; k++)
    begin
      send_word(words[k-1], k == 1, k == eop_at);
    end
    in_valid_i <= 1'b0;
    in_sop_i   <= 1'b0;
    in_eop_i   <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < TIMEOUT)
    begin
      @(negedge pck_proc_int_mem_fsm_clk);
      t++;
    end
    if (exp_q.size() != 0)
    begin
      err_cnt++;
      $display("Timeout: %0d expected words never came out", exp_q.size());
    end
    @(negedge pck_proc_int_mem_fsm_clk);
  endtask

  task automatic end_test(input string label, input int errs0);
    test_cnt++;
    if (err_cnt == errs0)
    begin
      $display("test %0d %s: ok", test_cnt, label);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, label, err_cnt - errs0);
    end
  endtask

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------

  always @(posedge pck_proc_int_mem_fsm_clk)
  begin
    if (ready_mode == 1)
    begin
      out_ready_i <= (rand_bits(1) != '0);
    end
    else
    begin
      out_ready_i <= (ready_mode == 0);
    end
  end

  initial
  begin
    logic       held;
    data_t      held_data;
    logic [1:0] held_flags;
    logic [1:0] flags;
    held = 1'b0;
    forever
    begin
      @(negedge pck_proc_int_mem_fsm_clk);
      drop_cnt += int'(packet_drop_o === 1'b1);
      ovf_cnt  += int'(overflow_o === 1'b1);
      if (wr_lvl_o > peak)
      begin
        peak = wr_lvl_o;
      end
      full_seen = full_seen | (full_o === 1'b1);
      // Stalled word must not move
      if (held)
      begin
        check_flag("out_valid_o", out_valid_o, 1'b1);
        check_data("out_data_o", out_data_o, held_data);
        check_flag("out_sop_o", out_sop_o, held_flags[1]);
        check_flag("out_eop_o", out_eop_o, held_flags[0]);
      end
      held       = out_valid_o && !out_ready_i;
      held_data  = out_data_o;
      held_flags = {out_sop_o, out_eop_o};
      if (out_valid_o && out_ready_i)
      begin
        if (exp_q.size() == 0)
        begin
          err_cnt++;
          $display("Output word %h appeared with no packet expected", out_data_o);
        end
        else
        begin
          flags = exp_flag_q.pop_front();
          check_data("out_data_o", out_data_o, exp_q.pop_front());
          check_flag("out_sop_o", out_sop_o, flags[1]);
          check_flag("out_eop_o", out_eop_o, flags[0]);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial
  begin
    int errs0;
    int i;
    pck_proc_int_mem_fsm_rstn = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_sop_i    = 1'b0;
    in_eop_i    = 1'b0;
    out_ready_i = 1'b0;
    ready_mode  = 0;
    err_cnt     = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    drop_cnt    = 0;
    ovf_cnt     = 0;
    peak        = '0;
    full_seen   = 1'b0;
    // len, words, eop at, second packet, stall, keep, drops, overflows
    rows = '{
      '{1, 1, 1, 0, 0, 1, 0, 0}, '{2, 2, 2, 0, 0, 1, 0, 0}, '{8, 8, 8, 0, 0, 1, 0, 0},
      '{0, 1, 1, 0, 0, 0, 1, 0}, '{4, 4, 4, 0, 0, 1, 0, 0}, '{5, 3, 3, 0, 0, 0, 1, 0},
      '{3, 3, 3, 0, 0, 1, 0, 0}, '{3, 5, 5, 0, 0, 0, 1, 0}, '{2, 2, 2, 0, 0, 1, 0, 0},
      '{6, 3, 0, 3, 0, 0, 1, 0}, '{8, 8, 8, 0, 1, 1, 0, 0}, '{5, 5, 5, 0, 1, 1, 0, 0},
      '{1, 1, 1, 0, 1, 1, 0, 0}, '{8, 8, 8, 0, 2, 1, 0, 0}, '{8, 8, 8, 0, 2, 1, 0, 0},
      '{8, 8, 8, 0, 2, 1, 0, 0}, '{8, 8, 8, 0, 2, 1, 0, 0}, '{8, 8, 8, 0, 2, 1, 0, 0},
      '{8, 8, 8, 0, 2, 1, 0, 0}, '{8, 8, 8, 0, 2, 1, 0, 0}, '{4, 4, 4, 0, 2, 1, 0, 0},
      '{8, 8, 8, 0, 2, 0, 1, 1}
    };

    repeat (2) @(posedge pck_proc_int_mem_fsm_clk);
    @(negedge pck_proc_int_mem_fsm_clk);
    errs0 = err_cnt;
    // Input closed while reset is held
    check_flag("in_ready_o", in_ready_o, 1'b0);
    @(posedge pck_proc_int_mem_fsm_clk);
    pck_proc_int_mem_fsm_rstn <= 1'b1;
    @(negedge pck_proc_int_mem_fsm_clk);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("packet_drop_o", packet_drop_o, 1'b0);
    check_flag("overflow_o", overflow_o, 1'b0);
    check_flag("full_o", full_o, 1'b0);
    check_flag("empty_o", empty_o, 1'b1);
    check_lvl("wr_lvl_o", wr_lvl_o, '0);
    end_test("reset values", errs0);

    for (i = 0; i < NROWS; i++)
    begin
      errs0      = err_cnt;
      drop_cnt   = 0;
      ovf_cnt    = 0;
      peak       = '0;
      full_seen  = 1'b0;
      ready_mode = rows[i][C_STALL];
      send_packet(rows[i][C_LEN], rows[i][C_NW], rows[i][C_EOP], rows[i][C_KEEP]);
      if (rows[i][C_SOP2] != 0)
      begin
        send_packet(rows[i][C_SOP2], rows[i][C_SOP2], rows[i][C_SOP2], 1);
      end
      repeat (2) @(negedge pck_proc_int_mem_fsm_clk);
      check_count("packet_drop_o pulses", drop_cnt, rows[i][C_DROPS]);
      check_count("overflow_o pulses", ovf_cnt, rows[i][C_OVF]);
      if (rows[i][C_STALL] != 2)
      begin
        wait_drain();
      end
      if (rows[i][C_OVF] != 0)
      begin
        check_lvl("wr_lvl_o peak", peak, lvl_t'(DEPTH));
        check_flag("full_o seen", full_seen, 1'b1);
        check_lvl("wr_lvl_o", wr_lvl_o, lvl_t'(STORED));
      end
      end_test($sformatf("row %0d len %0d words %0d", i, rows[i][C_LEN], rows[i][C_NW]),
               errs0);
    end

    errs0      = err_cnt;
    ready_mode = 0;
    wait_drain();
    repeat (4) @(negedge pck_proc_int_mem_fsm_clk);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("empty_o", empty_o, 1'b1);
    check_lvl("wr_lvl_o", wr_lvl_o, '0);
    check_flag("in_ready_o", in_ready_o, 1'b1);
    end_test("drain after overflow", errs0);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
src/pck_buf_pkg.sv
src/pck_write_ctrl.sv
src/pck_data_ram.sv
src/pck_len_fifo.sv
src/pck_read_ctrl.sv
src/pck_proc_int_mem_fsm.sv
bench/pck_proc_tb.sv

// File: src/pck_buf_pkg.sv
package pck_buf_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------

  // Packet word width
  localparam int DATA_W = 32;

  // Word memory of 64 entries
  localparam int ADDR_W = 6;
  localparam int DEPTH  = 64;

  // Length field in the low bits of the header word
  localparam int LEN_W = 12;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  typedef logic [DATA_W-1:0] data_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // One extra bit so a full memory reads as DEPTH
  typedef logic [ADDR_W:0] lvl_t;

  typedef logic [LEN_W-1:0] len_t;

  // ----------------------------------------------------------
  // State machines
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_DISCARD
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_STREAM
  } rd_state_e;

endpackage

// File: src/pck_data_ram.sv
module pck_data_ram
  import pck_buf_pkg::*;
(
  input  logic  pck_proc_int_mem_fsm_clk,
  input  logic  pck_proc_int_mem_fsm_rstn,
  input  logic  wr_en_i,
  input  data_t wr_data_i,
  input  logic  commit_i,
  input  logic  rollback_i,
  input  logic  rd_en_i,
  output data_t rd_data_o,
  output logic  full_o,
  output logic  empty_o,
  output lvl_t  wr_lvl_o
);

  data_t mem [DEPTH];

  addr_t wr_ptr_q;
  addr_t cmt_ptr_q;
  addr_t rd_ptr_q;
  addr_t wr_addr;
  addr_t wr_ptr_d;
  lvl_t  spec_cnt_q;
  lvl_t  spec_cnt_d;
  lvl_t  lvl_q;
  lvl_t  lvl_d;

  // ----------------------------------------------------------
  // Pointer and level update
  // ----------------------------------------------------------

  // A rollback restarts writing at the committed position
  assign wr_addr  = rollback_i ? cmt_ptr_q : wr_ptr_q;
  assign wr_ptr_d = wr_addr + addr_t'(wr_en_i);

  always_comb
  begin
    spec_cnt_d = rollback_i ? lvl_t'(0) : spec_cnt_q;
    if (commit_i)
    begin
      spec_cnt_d = '0;
    end
    else
    begin
      spec_cnt_d = spec_cnt_d + lvl_t'(wr_en_i);
    end
  end

  // Uncommitted words leave the level on a rollback
  assign lvl_d = lvl_q - (rollback_i ? spec_cnt_q : lvl_t'(0))
               + lvl_t'(wr_en_i) - lvl_t'(rd_en_i);

  always_ff @(posedge pck_proc_int_mem_fsm_clk or negedge pck_proc_int_mem_fsm_rstn)
  begin
    if (!pck_proc_int_mem_fsm_rstn)
    begin
      wr_ptr_q   <= '0;
      cmt_ptr_q  <= '0;
      rd_ptr_q   <= '0;
      spec_cnt_q <= '0;
      lvl_q      <= '0;
      full_o     <= 1'b0;
      empty_o    <= 1'b1;
    end
    else
    begin
      wr_ptr_q   <= wr_ptr_d;
      spec_cnt_q <= spec_cnt_d;
      lvl_q      <= lvl_d;
      full_o     <= (lvl_d == lvl_t'(DEPTH));
      empty_o    <= (lvl_d == '0);
      if (commit_i)
      begin
        cmt_ptr_q <= wr_ptr_d;
      end
      if (rd_en_i)
      begin
        rd_ptr_q <= rd_ptr_q + addr_t'(1);
      end
    end
  end

  assign wr_lvl_o = lvl_q;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  always_ff @(posedge pck_proc_int_mem_fsm_clk)
  begin
    if (wr_en_i)
    begin
      mem[wr_addr] <= wr_data_i;
    end
  end

  assign rd_data_o = mem[rd_ptr_q];

  a_no_write_when_full : assert property (
    @(posedge pck_proc_int_mem_fsm_clk) disable iff (!pck_proc_int_mem_fsm_rstn)
    (wr_en_i && !rollback_i) |-> !full_o
  );

endmodule

// File: src/pck_len_fifo.sv
module pck_len_fifo
  import pck_buf_pkg::*;
(
  input  logic pck_proc_int_mem_fsm_clk,
  input  logic pck_proc_int_mem_fsm_rstn,
  input  logic push_i,
  input  len_t push_len_i,
  input  logic pop_i,
  output logic len_valid_o,
  output len_t len_head_o
);

  len_t  len_mem [DEPTH];
  addr_t wr_ptr_q;
  addr_t rd_ptr_q;
  lvl_t  cnt_q;

  // One entry per committed packet, so never more than DEPTH
  always_ff @(posedge pck_proc_int_mem_fsm_clk or negedge pck_proc_int_mem_fsm_rstn)
  begin
    if (!pck_proc_int_mem_fsm_rstn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr_q <= wr_ptr_q + addr_t'(1);
      end
      if (pop_i)
      begin
        rd_ptr_q <= rd_ptr_q + addr_t'(1);
      end
      cnt_q <= cnt_q + lvl_t'(push_i) - lvl_t'(pop_i);
    end
  end

  always_ff @(posedge pck_proc_int_mem_fsm_clk)
  begin
    if (push_i)
    begin
      len_mem[wr_ptr_q] <= push_len_i;
    end
  end

  assign len_valid_o = (cnt_q != '0);
  assign len_head_o  = len_mem[rd_ptr_q];

  a_no_pop_when_empty : assert property (
    @(posedge pck_proc_int_mem_fsm_clk) disable iff (!pck_proc_int_mem_fsm_rstn)
    pop_i |-> len_valid_o
  );

endmodule

// File: src/pck_proc_int_mem_fsm.sv
module pck_proc_int_mem_fsm
  import pck_buf_pkg::*;
(
  input  logic  pck_proc_int_mem_fsm_clk,
  input  logic  pck_proc_int_mem_fsm_rstn,
  input  logic  in_valid_i,
  input  data_t in_data_i,
  input  logic  in_sop_i,
  input  logic  in_eop_i,
  output logic  in_ready_o,
  output logic  out_valid_o,
  output data_t out_data_o,
  output logic  out_sop_o,
  output logic  out_eop_o,
  input  logic  out_ready_i,
  output logic  packet_drop_o,
  output logic  overflow_o,
  output logic  full_o,
  output logic  empty_o,
  output lvl_t  wr_lvl_o
);

  logic  wr_en;
  data_t wr_data;
  logic  commit;
  logic  rollback;
  logic  len_push;
  len_t  len_data;
  logic  len_valid;
  len_t  len_head;
  logic  len_pop;
  logic  rd_en;
  data_t rd_data;

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------

  pck_write_ctrl pck_write_ctrl_inst (
    .pck_proc_int_mem_fsm_clk  (pck_proc_int_mem_fsm_clk),
    .pck_proc_int_mem_fsm_rstn (pck_proc_int_mem_fsm_rstn),
    .in_valid_i                (in_valid_i),
    .in_data_i                 (in_data_i),
    .in_sop_i                  (in_sop_i),
    .in_eop_i                  (in_eop_i),
    .in_ready_o                (in_ready_o),
    .full_i                    (full_o),
    .wr_en_o                   (wr_en),
    .wr_data_o                 (wr_data),
    .commit_o                  (commit),
    .rollback_o                (rollback),
    .len_push_o                (len_push),
    .len_data_o                (len_data),
    .packet_drop_o             (packet_drop_o),
    .overflow_o                (overflow_o)
  );

  pck_data_ram pck_data_ram_inst (
    .pck_proc_int_mem_fsm_clk  (pck_proc_int_mem_fsm_clk),
    .pck_proc_int_mem_fsm_rstn (pck_proc_int_mem_fsm_rstn),
    .wr_en_i                   (wr_en),
    .wr_data_i                 (wr_data),
    .commit_i                  (commit),
    .rollback_i                (rollback),
    .rd_en_i                   (rd_en),
    .rd_data_o                 (rd_data),
    .full_o                    (full_o),
    .empty_o                   (empty_o),
    .wr_lvl_o                  (wr_lvl_o)
  );

  pck_len_fifo pck_len_fifo_inst (
    .pck_proc_int_mem_fsm_clk  (pck_proc_int_mem_fsm_clk),
    .pck_proc_int_mem_fsm_rstn (pck_proc_int_mem_fsm_rstn),
    .push_i                    (len_push),
    .push_len_i                (len_data),
    .pop_i                     (len_pop),
    .len_valid_o               (len_valid),
    .len_head_o                (len_head)
  );

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------

  pck_read_ctrl pck_read_ctrl_inst (
    .pck_proc_int_mem_fsm_clk  (pck_proc_int_mem_fsm_clk),
    .pck_proc_int_mem_fsm_rstn (pck_proc_int_mem_fsm_rstn),
    .len_valid_i               (len_valid),
    .len_head_i                (len_head),
    .len_pop_o                 (len_pop),
    .rd_en_o                   (rd_en),
    .rd_data_i                 (rd_data),
    .out_valid_o               (out_valid_o),
    .out_data_o                (out_data_o),
    .out_sop_o                 (out_sop_o),
    .out_eop_o                 (out_eop_o),
    .out_ready_i               (out_ready_i)
  );

endmodule

// File: src/pck_read_ctrl.sv
module pck_read_ctrl
  import pck_buf_pkg::*;
(
  input  logic  pck_proc_int_mem_fsm_clk,
  input  logic  pck_proc_int_mem_fsm_rstn,
  input  logic  len_valid_i,
  input  len_t  len_head_i,
  output logic  len_pop_o,
  output logic  rd_en_o,
  input  data_t rd_data_i,
  output logic  out_valid_o,
  output data_t out_data_o,
  output logic  out_sop_o,
  output logic  out_eop_o,
  input  logic  out_ready_i
);

  rd_state_e state_q;
  len_t      remain_q;
  logic      xfer;
  logic      last_done;
  logic      start;
  logic      next_word;

  // Words still to load after the one in the output register
  assign xfer      = out_valid_o && out_ready_i;
  assign last_done = xfer && (remain_q == '0);
  assign next_word = xfer && (remain_q != '0);

  // Next packet may follow its predecessor back to back
  assign start = len_valid_i && ((state_q == RD_IDLE) || last_done);

  assign len_pop_o = start;
  assign rd_en_o   = start || next_word;

  // ----------------------------------------------------------
  // Read FSM and output register
  // ----------------------------------------------------------

  always_ff @(posedge pck_proc_int_mem_fsm_clk or negedge pck_proc_int_mem_fsm_rstn)
  begin
    if (!pck_proc_int_mem_fsm_rstn)
    begin
      state_q     <= RD_IDLE;
      remain_q    <= '0;
      out_valid_o <= 1'b0;
      out_sop_o   <= 1'b0;
      out_eop_o   <= 1'b0;
    end
    else if (start)
    begin
      state_q     <= RD_STREAM;
      remain_q    <= len_head_i - len_t'(1);
      out_valid_o <= 1'b1;
      out_sop_o   <= 1'b1;
      out_eop_o   <= (len_head_i == len_t'(1));
    end
    else if (next_word)
    begin
      remain_q  <= remain_q - len_t'(1);
      out_sop_o <= 1'b0;
      out_eop_o <= (remain_q == len_t'(1));
    end
    else if (last_done)
    begin
      state_q     <= RD_IDLE;
      out_valid_o <= 1'b0;
      out_sop_o   <= 1'b0;
      out_eop_o   <= 1'b0;
    end
  end

  always_ff @(posedge pck_proc_int_mem_fsm_clk)
  begin
    if (rd_en_o)
    begin
      out_data_o <= rd_data_i;
    end
  end

  a_hold_on_stall : assert property (
    @(posedge pck_proc_int_mem_fsm_clk) disable iff (!pck_proc_int_mem_fsm_rstn)
    (out_valid_o && !out_ready_i)
      |=> $stable({out_valid_o, out_data_o, out_sop_o, out_eop_o})
  );

endmodule

// File: src/pck_write_ctrl.sv
module pck_write_ctrl
  import pck_buf_pkg::*;
(
  input  logic  pck_proc_int_mem_fsm_clk,
  input  logic  pck_proc_int_mem_fsm_rstn,
  input  logic  in_valid_i,
  input  data_t in_data_i,
  input  logic  in_sop_i,
  input  logic  in_eop_i,
  output logic  in_ready_o,
  input  logic  full_i,
  output logic  wr_en_o,
  output data_t wr_data_o,
  output logic  commit_o,
  output logic  rollback_o,
  output logic  len_push_o,
  output len_t  len_data_o,
  output logic  packet_drop_o,
  output logic  overflow_o
);

  wr_state_e state_q;
  wr_state_e state_d;
  len_t      hdr_len_q;
  len_t      hdr_len_d;
  len_t      word_cnt_q;
  len_t      word_cnt_d;
  logic      ready_en_q;
  logic      accept;
  logic      drop;
  len_t      sop_len;
  len_t      word_num;

  // Input stays closed until the first edge out of reset
  assign in_ready_o = ready_en_q && !(full_i && (state_q == WR_IDLE));
  assign accept     = in_valid_i && in_ready_o;

  assign sop_len  = in_data_i[LEN_W-1:0];
  assign word_num = word_cnt_q + len_t'(1);

  assign wr_data_o     = in_data_i;
  assign rollback_o    = drop;
  assign packet_drop_o = drop;
  assign len_push_o    = commit_o;
  assign len_data_o    = in_sop_i ? sop_len : hdr_len_q;

  // ----------------------------------------------------------
  // Length check and drop decision
  // ----------------------------------------------------------

  always_comb
  begin
    state_d    = state_q;
    hdr_len_d  = hdr_len_q;
    word_cnt_d = word_cnt_q;
    wr_en_o    = 1'b0;
    commit_o   = 1'b0;
    drop       = 1'b0;
    overflow_o = 1'b0;
    if (accept)
    begin
      if (in_sop_i)
      begin
        // Any open packet is lost
        drop       = (state_q == WR_DATA);
        hdr_len_d  = sop_len;
        word_cnt_d = len_t'(1);
        if ((sop_len == '0) || ((sop_len == len_t'(1)) != in_eop_i))
        begin
          drop    = 1'b1;
          state_d = in_eop_i ? WR_IDLE : WR_DISCARD;
        end
        else if (in_eop_i && (state_q == WR_DATA))
        begin
          // Single-word packet goes down with the open one
          state_d = WR_IDLE;
        end
        else if (in_eop_i)
        begin
          wr_en_o  = 1'b1;
          commit_o = 1'b1;
          state_d  = WR_IDLE;
        end
        else
        begin
          wr_en_o = 1'b1;
          state_d = WR_DATA;
        end
      end
      else if (state_q == WR_DATA)
      begin
        word_cnt_d = word_num;
        if (full_i || (in_eop_i != (word_num == hdr_len_q)))
        begin
          drop       = 1'b1;
          overflow_o = full_i;
          state_d    = in_eop_i ? WR_IDLE : WR_DISCARD;
        end
        else
        begin
          wr_en_o  = 1'b1;
          commit_o = in_eop_i;
          state_d  = in_eop_i ? WR_IDLE : WR_DATA;
        end
      end
      else if ((state_q == WR_DISCARD) && in_eop_i)
      begin
        state_d = WR_IDLE;
      end
    end
  end

  always_ff @(posedge pck_proc_int_mem_fsm_clk or negedge pck_proc_int_mem_fsm_rstn)
  begin
    if (!pck_proc_int_mem_fsm_rstn)
    begin
      state_q    <= WR_IDLE;
      hdr_len_q  <= '0;
      word_cnt_q <= '0;
      ready_en_q <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      hdr_len_q  <= hdr_len_d;
      word_cnt_q <= word_cnt_d;
      ready_en_q <= 1'b1;
    end
  end

  a_commit_not_rollback : assert property (
    @(posedge pck_proc_int_mem_fsm_clk) disable iff (!pck_proc_int_mem_fsm_rstn)
    !(commit_o && rollback_o)
  );

endmodule
